// File: sources.f
design/clk_ctrl_pkg.sv
design/cfg_if.sv
design/cfg_front.sv
design/postscaler_chan.sv
design/pll_loop_regs.sv
design/cfg_readback.sv
design/clk_and_control.sv
testbench/tb_clk_and_control.sv

// File: Bender.yml
package:
  name: clk_and_control

sources:
  - design/clk_ctrl_pkg.sv
  - design/cfg_if.sv
  - design/cfg_front.sv
  - design/postscaler_chan.sv
  - design/pll_loop_regs.sv
  - design/cfg_readback.sv
  - design/clk_and_control.sv
  - target: test
    files:
      - testbench/tb_clk_and_control.sv

// File: testbench/tb_clk_and_control.sv
// testbench for the pll config block
// host register access, lock timer, divider and gating tests
`timescale 1ns/1ps
`default_nettype none

module tb_clk_and_control;

  localparam int CLK_PERIOD = 40;
  localparam int MAX_CYCLES = 4000;  // ~45 accesses of 5 cycles plus ~400 cycles of waits
  localparam int ACK_LAT    = 3;     // clocks from req driven to ack seen
  localparam logic [4:0]  A_CH0  = 5'd0;
  localparam logic [4:0]  A_CH1  = 5'd4;
  localparam logic [4:0]  A_MUL  = 5'd8;
  localparam logic [4:0]  A_SSC  = 5'd12;
  localparam logic [4:0]  A_LDET = 5'd16;
  localparam logic [4:0]  A_LF   = 5'd20;
  localparam logic [4:0]  A_SCR0 = 5'd24;
  localparam logic [4:0]  A_SCR1 = 5'd28;
  localparam logic [31:0] REL    = 32'h0000_0004;  // pll reset release
  localparam logic [31:0] EN     = 32'h0004_0000;
  localparam logic [31:0] BYP    = 32'h0008_0000;
  localparam logic [31:0] DIV5   = 32'd5 << 4;     // level-2 divider of 5
  localparam logic [31:0] CH_RST = BYP;            // bypass only
  localparam logic [31:0] MUL_RST = (32'd1 << 28) | (32'd1 << 27) | (32'd40 << 4);
  localparam logic [31:0] MUL_NEW = (32'd3 << 28) | (32'h123 << 15) | (32'd100 << 4);

  logic        clk;
  logic        RSTB;
  logic        cfg_req;
  logic        cfg_we_n;
  logic [4:0]  cfg_addr;
  logic [31:0] cfg_wdata;
  logic        cfg_ack;
  logic [31:0] cfg_rdata;
  logic        lock;
  logic [1:0]  chan_clk_en;
  logic [10:0] mul_int;
  logic [3:0]  prescale;
  logic        integer_mode;

  int          errors = 0;
  int          checks = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          cycle_cnt = 0;
  int unsigned seed;
  logic [31:0] scr0_val;  // kept for the handshake test

  clk_and_control #(.NUM_CHAN(2)) dut_i (
    .clk(clk), .RSTB(RSTB), .cfg_req(cfg_req), .cfg_we_n(cfg_we_n),
    .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_ack(cfg_ack),
    .cfg_rdata(cfg_rdata), .lock(lock), .chan_clk_en(chan_clk_en),
    .mul_int(mul_int), .prescale(prescale), .integer_mode(integer_mode)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles, tests did not finish", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic next_cycle();  // inputs change and outputs sampled 2 ns after the edge
    @(posedge clk);
    #2;
  endtask

  // raise req and wait for ack, req stays high on return
  task automatic issue_req(input logic we_n, input logic [4:0] addr, input logic [31:0] wdata);
    int n;
    cfg_req   = 1'b1;
    cfg_we_n  = we_n;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    next_cycle();
    n = 1;
    while (!cfg_ack && n < 10) begin
      next_cycle();
      n++;
    end
    checks++;
    if (!cfg_ack) begin
      $display("no cfg_ack within 10 cycles for address %h", addr);
      errors++;
    end else if (n != ACK_LAT) begin
      $display("Fail cfg_ack latency: got %h, expected %h", n, ACK_LAT);
      errors++;
    end
  endtask

  task automatic release_req();  // one low cycle re-arms the front end
    cfg_req = 1'b0;
    next_cycle();
  endtask

  task automatic cfg_write(input logic [4:0] addr, input logic [31:0] data);
    issue_req(1'b0, addr, data);
    release_req();
  endtask

  task automatic cfg_read(input logic [4:0] addr, output logic [31:0] data);
    issue_req(1'b1, addr, 32'h0);
    data = cfg_rdata;  // valid in the ack cycle
    release_req();
  endtask

  task automatic read_check(input string name, input logic [4:0] addr, input logic [31:0] exp);
    logic [31:0] d;
    cfg_read(addr, d);
    check_eq(name, d, exp);
  endtask

  task automatic count_pulses(input int cycles, output int c0, output int c1);
    c0 = 0;
    c1 = 0;
    repeat (cycles) begin
      next_cycle();
      c0 += chan_clk_en[0];
      c1 += chan_clk_en[1];
    end
  endtask

  task automatic wait_lock(output int n);
    n = 0;
    while (!lock && n < 100) begin
      next_cycle();
      n++;
    end
  endtask

  task automatic end_test(input string name, input int base);
    if (errors == base) begin
      tests_ok++;
      $display("test %s: pass", name);
    end else begin
      tests_bad++;
      $display("test %s: fail, %0d errors", name, errors - base);
    end
  endtask

  task automatic reset_values();
    int base;
    base = errors;
    check_eq("cfg_ack", cfg_ack, 0);
    check_eq("cfg_rdata", cfg_rdata, 0);
    check_eq("chan_clk_en", chan_clk_en, 0);
    check_eq("lock", lock, 0);
    check_eq("mul_int", mul_int, 40);
    check_eq("prescale", prescale, 1);
    check_eq("integer_mode", integer_mode, 1);
    read_check("chan0", A_CH0, CH_RST);
    read_check("chan1", A_CH1, CH_RST);
    read_check("mul", A_MUL, MUL_RST);
    read_check("ssc", A_SSC, 32'h0);
    read_check("ldet", A_LDET, 32'h64);  // lock bit clear
    read_check("lf", A_LF, 32'h269);
    read_check("scratch0", A_SCR0, 32'h0);
    read_check("scratch1", A_SCR1, 32'h0);
    end_test("reset values", base);
  endtask

  task automatic reg_access();
    int          base;
    logic [31:0] w1;
    logic [31:0] w2;
    base     = errors;
    scr0_val = $urandom;
    w1       = $urandom;
    w2       = $urandom;
    cfg_write(A_SCR0, scr0_val);
    cfg_write(A_SCR1, w1);
    cfg_write(A_SSC, w2);
    read_check("scratch0", A_SCR0, scr0_val);
    read_check("scratch1", A_SCR1, w1);
    read_check("ssc", A_SSC, w2);
    cfg_write(A_MUL, MUL_NEW);
    check_eq("mul_int", mul_int, 100);
    check_eq("prescale", prescale, 3);
    check_eq("integer_mode", integer_mode, 0);
    read_check("mul", A_MUL, MUL_NEW);
    cfg_write(5'd30, w1);  // past the last register
    read_check("unmapped", 5'd30, 32'h0);
    read_check("chan1 after stray write", A_CH1, CH_RST);
    end_test("register access", base);
  endtask

  task automatic lock_timer();
    int base;
    int n;
    base = errors;
    cfg_write(A_LDET, 32'd20);
    check_eq("lock before release", lock, 0);
    cfg_write(A_CH0, CH_RST | REL);
    wait_lock(n);
    n = n + 1;  // one cycle already spent in release_req
    checks++;
    if (n < 19 || n > 21) begin
      $display("Fail lock delay: got %h, expected %h to %h", n, 19, 21);
      errors++;
    end
    read_check("ldet with lock", A_LDET, 32'h8000_0014);
    cfg_write(A_MUL, MUL_NEW);  // retune drops lock
    check_eq("lock after mul write", lock, 0);
    end_test("lock timer", base);
  endtask

  task automatic divider_rates();
    int base;
    int n;
    int c0;
    int c1;
    base = errors;
    wait_lock(n);
    check_eq("lock before divider", lock, 1);
    cfg_write(A_CH0, REL | EN | DIV5);
    cfg_write(A_CH1, EN | BYP);
    count_pulses(100, c0, c1);
    checks++;
    if (c0 < 19 || c0 > 21) begin
      $display("Fail chan0 pulses: got %h, expected %h to %h", c0, 19, 21);
      errors++;
    end
    check_eq("chan1 pulses", c1, 100);  // bypass, every cycle
    end_test("divider", base);
  endtask

  task automatic enable_gating();
    int base;
    int c0;
    int c1;
    base = errors;
    cfg_write(A_CH0, REL | DIV5);  // enable off
    count_pulses(20, c0, c1);
    check_eq("chan0 pulses disabled", c0, 0);
    check_eq("lock with release held", lock, 1);
    cfg_write(A_CH0, EN | DIV5);  // release off
    check_eq("lock after release cleared", lock, 0);
    count_pulses(20, c0, c1);
    check_eq("chan0 pulses unlocked", c0, 0);
    check_eq("chan1 pulses unlocked", c1, 20);
    end_test("gating", base);
  endtask

  task automatic handshake_discipline();
    int          base;
    int          acks;
    logic [31:0] w;
    base = errors;
    acks = 0;
    issue_req(1'b1, A_SCR0, 32'h0);
    check_eq("held read data", cfg_rdata, scr0_val);
    repeat (10) begin  // req stays high
      next_cycle();
      if (cfg_ack) acks++;
    end
    check_eq("extra acks", acks, 0);
    release_req();
    w = $urandom;
    cfg_write(A_SCR1, w);
    read_check("scratch1 after re-arm", A_SCR1, w);
    end_test("handshake", base);
  endtask

  initial begin
    seed = 32'hd88a36ef;
    void'($urandom(seed));
    RSTB      = 1'b0;
    cfg_req   = 1'b0;
    cfg_we_n  = 1'b1;
    cfg_addr  = 5'd0;
    cfg_wdata = 32'h0;
    repeat (3) @(posedge clk);
    #2;
    RSTB = 1'b1;
    next_cycle();
    reset_values();
    reg_access();
    lock_timer();
    divider_rates();
    enable_gating();
    handshake_discipline();
    $display("checks %0d, errors %0d, tests passed %0d, tests failed %0d",
             checks, errors, tests_ok, tests_bad);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/clk_and_control.sv
// top level of the pll config and clock-control block
// host port, post-scaler channels and loop registers
`timescale 1ns/1ps
`default_nettype none

module clk_and_control import clk_ctrl_pkg::*; #(
  parameter int NUM_CHAN = 2  // 1 or 2
) (
  input  logic                              clk,
  input  logic                              RSTB,
  input  logic                              cfg_req,
  input  logic                              cfg_we_n,
  input  logic [ADDR_W-1:0]                 cfg_addr,
  input  logic [DATA_W-1:0]                 cfg_wdata,
  output logic                              cfg_ack,
  output logic [DATA_W-1:0]                 cfg_rdata,
  output logic                              lock,
  output logic [NUM_CHAN-1:0]               chan_clk_en,
  output logic [MUL_INT_MSB-MUL_INT_LSB:0]  mul_int,
  output logic [MUL_PRE_MSB-MUL_PRE_LSB:0]  prescale,
  output logic                              integer_mode
);

  logic [NUM_CHAN-1:0][DATA_W-1:0] chan_words;
  logic [NUM_CHAN-1:0]             rst_rel;    // only bit 0 drives the pll
  logic [DATA_W-1:0]               loop_word;

  cfg_if #(.NUM_CHAN(NUM_CHAN)) acc_if ();

  cfg_front #(.NUM_CHAN(NUM_CHAN)) front_i (
    .clk       (clk),
    .RSTB      (RSTB),
    .cfg_req   (cfg_req),
    .cfg_we_n  (cfg_we_n),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .acc       (acc_if.src)
  );

  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    postscaler_chan chan_i (
      .clk         (clk),
      .RSTB        (RSTB),
      .lock        (lock),
      .acc         (acc_if.regs),
      .sel_idx     (acc_if.sel[i]),
      .chan_word   (chan_words[i]),
      .pll_rst_rel (rst_rel[i]),
      .clk_en      (chan_clk_en[i])
    );
  end

  pll_loop_regs loop_i (
    .clk          (clk),
    .RSTB         (RSTB),
    .pll_rst_rel  (rst_rel[0]),
    .acc          (acc_if.regs),
    .rd_word      (loop_word),
    .lock         (lock),
    .mul_int      (mul_int),
    .prescale     (prescale),
    .integer_mode (integer_mode)
  );

  cfg_readback #(.NUM_CHAN(NUM_CHAN)) readback_i (
    .clk        (clk),
    .RSTB       (RSTB),
    .acc        (acc_if.mon),
    .chan_words (chan_words),
    .loop_word  (loop_word),
    .cfg_ack    (cfg_ack),
    .cfg_rdata  (cfg_rdata)
  );

endmodule

`default_nettype wire

// File: design/cfg_readback.sv
// acknowledge and read data path back to the host
`timescale 1ns/1ps
`default_nettype none

module cfg_readback import clk_ctrl_pkg::*; #(
  parameter int NUM_CHAN = 2
) (
  input  logic                             clk,
  input  logic                             RSTB,
  cfg_if.mon                               acc,
  input  logic [NUM_CHAN-1:0][DATA_W-1:0]  chan_words,
  input  logic [DATA_W-1:0]                loop_word,
  output logic                             cfg_ack,
  output logic [DATA_W-1:0]                cfg_rdata
);

  logic              v_q;    // access seen, register stage
  logic              rd_q;   // that access was a read
  logic [NUM_CHAN:0] sel_q;
  logic [DATA_W-1:0] rd_mux;

  // lines up with the register update / read select cycle
  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      v_q   <= 1'b0;
      rd_q  <= 1'b0;
      sel_q <= '0;
    end else begin
      v_q   <= acc.valid;
      rd_q  <= acc.valid & ~acc.req.we;
      sel_q <= acc.sel;
    end
  end

  // one-hot or-mux over channels and loop block
  always_comb begin
    rd_mux = '0;
    for (int i = 0; i < NUM_CHAN; i++) begin
      if (sel_q[i]) rd_mux = rd_mux | chan_words[i];
    end
    if (sel_q[NUM_CHAN]) rd_mux = rd_mux | loop_word;  // zero for unmapped
  end

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      cfg_ack   <= 1'b0;
      cfg_rdata <= '0;
    end else begin
      cfg_ack <= v_q;  // single pulse per access
      if (rd_q) begin
        cfg_rdata <= rd_mux;  // held until the next read
      end
    end
  end

endmodule

`default_nettype wire

// File: design/pll_loop_regs.sv
// loop setting registers, scratch registers and lock timer
// lock timer stands in for the analog pll lock detector
`timescale 1ns/1ps
`default_nettype none

module pll_loop_regs import clk_ctrl_pkg::*; (
  input  logic                               clk,
  input  logic                               RSTB,
  input  logic                               pll_rst_rel,
  cfg_if.regs                                acc,
  output logic [DATA_W-1:0]                  rd_word,
  output logic                               lock,
  output logic [MUL_INT_MSB-MUL_INT_LSB:0]   mul_int,
  output logic [MUL_PRE_MSB-MUL_PRE_LSB:0]   prescale,
  output logic                               integer_mode
);

  logic [DATA_W-1:0] mul_q;
  logic [DATA_W-1:0] ssc_q;
  logic [DATA_W-1:0] ldet_q;
  logic [DATA_W-1:0] lf_q;
  logic [DATA_W-1:0] scr0_q;
  logic [DATA_W-1:0] scr1_q;
  logic [LDET_LF_MSB-LDET_LF_LSB:0] lf_hi_q;  // loop filter bits 34:32
  logic              wr;
  logic              loop_wr;
  logic [9:0]        lock_cnt_q;
  logic [9:0]        lock_target;
  logic              lock_q;

  assign wr      = acc.valid & acc.req.we;
  assign loop_wr = wr & ((acc.req.addr == ADDR_MUL) | (acc.req.addr == ADDR_LF));

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      mul_q   <= RST_MUL;
      ssc_q   <= '0;
      ldet_q  <= RST_LDET;
      lf_q    <= RST_LF;
      scr0_q  <= '0;
      scr1_q  <= '0;
      lf_hi_q <= '0;
    end else if (wr) begin
      case (acc.req.addr)
        ADDR_MUL:  mul_q  <= acc.req.wdata;
        ADDR_SSC:  ssc_q  <= acc.req.wdata;
        ADDR_LDET: ldet_q <= acc.req.wdata;
        ADDR_LF: begin
          lf_q    <= acc.req.wdata;
          lf_hi_q <= ldet_q[LDET_LF_MSB:LDET_LF_LSB];  // upper filter bits ride along
        end
        ADDR_SCR0: scr0_q <= acc.req.wdata;
        ADDR_SCR1: scr1_q <= acc.req.wdata;
        default: ;  // unmapped, dropped
      endcase
    end
  end

  // settle time = detect count, stretched by the upper filter bits
  assign lock_target = {1'b0, ldet_q[LDET_CNT_MSB:0]} + {7'd0, lf_hi_q};

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      lock_cnt_q <= '0;
      lock_q     <= 1'b0;
    end else if (!pll_rst_rel || loop_wr) begin
      lock_cnt_q <= '0;  // pll held in reset or loop retuned
      lock_q     <= 1'b0;
    end else if (!lock_q) begin
      if (lock_cnt_q >= lock_target) begin
        lock_q <= 1'b1;
      end else begin
        lock_cnt_q <= lock_cnt_q + 10'd1;
      end
    end
  end

  // read select, one cycle after the access strobe
  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      rd_word <= '0;
    end else if (acc.valid) begin
      case (acc.req.addr)
        ADDR_MUL:  rd_word <= mul_q;
        ADDR_SSC:  rd_word <= ssc_q;
        ADDR_LDET: rd_word <= {lock_q, ldet_q[LDET_LOCK-1:0]};  // live lock on top
        ADDR_LF:   rd_word <= lf_q;
        ADDR_SCR0: rd_word <= scr0_q;
        ADDR_SCR1: rd_word <= scr1_q;
        default:   rd_word <= '0;  // unmapped reads as zero
      endcase
    end
  end

  assign lock         = lock_q;
  assign mul_int      = mul_q[MUL_INT_MSB:MUL_INT_LSB];
  assign prescale     = mul_q[MUL_PRE_MSB:MUL_PRE_LSB];
  assign integer_mode = mul_q[MUL_IMODE];

endmodule

`default_nettype wire

// File: design/postscaler_chan.sv
// one post-scaler channel: config register and divider
// divider output is a clock-enable pulse on clk
`timescale 1ns/1ps
`default_nettype none

module postscaler_chan import clk_ctrl_pkg::*; (
  input  logic              clk,
  input  logic              RSTB,
  input  logic              lock,
  cfg_if.regs               acc,
  input  logic              sel_idx,
  output logic [DATA_W-1:0] chan_word,
  output logic              pll_rst_rel,
  output logic              clk_en
);

  logic [DATA_W-1:0] word_q;
  logic              wr_hit;
  logic [7:0]        l2_div;
  logic [7:0]        div_m1;
  logic [7:0]        cnt_q;
  logic              ch_en;
  logic              ch_byp;
  logic              running;
  logic              term;

  assign wr_hit = acc.valid & acc.req.we & sel_idx;  // write aimed at this channel

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      word_q <= RST_CHAN;
    end else if (wr_hit) begin
      word_q <= acc.req.wdata;
    end
  end

  assign l2_div = word_q[CH_L2_MSB:CH_L2_LSB];
  assign ch_en  = word_q[CH_EN];
  assign ch_byp = word_q[CH_BYP];

  assign div_m1  = (l2_div == 8'd0) ? 8'd0 : l2_div - 8'd1;  // zero means divide by 1
  assign running = ch_en & ~ch_byp & lock;  // divided path active
  assign term    = (cnt_q >= div_m1);       // terminal count

  // divider counter, restarts on any write to this channel
  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      cnt_q <= 8'd0;
    end else if (wr_hit || !running) begin
      cnt_q <= 8'd0;  // hold at start while idle
    end else if (term) begin
      cnt_q <= 8'd0;  // reload
    end else begin
      cnt_q <= cnt_q + 8'd1;
    end
  end

  // bypass passes the reference straight through
  assign clk_en = ch_en & (ch_byp | (lock & term));

  assign chan_word   = word_q;
  assign pll_rst_rel = word_q[CH_RST_REL];  // only chan 0 is wired up

endmodule

`default_nettype wire

// File: design/cfg_front.sv
// host request acceptor and address decoder
`timescale 1ns/1ps
`default_nettype none

module cfg_front import clk_ctrl_pkg::*; #(
  parameter int NUM_CHAN = 2
) (
  input  logic              clk,
  input  logic              RSTB,
  input  logic              cfg_req,
  input  logic              cfg_we_n,
  input  logic [ADDR_W-1:0] cfg_addr,
  input  logic [DATA_W-1:0] cfg_wdata,
  cfg_if.src                acc
);

  localparam int CHAN_STRIDE = int'(ADDR_CHAN1) - int'(ADDR_CHAN0);  // bytes per channel

  typedef enum logic {
    ST_IDLE,      // armed for a new request
    ST_WAIT_LOW   // request served, wait for req to drop
  } front_st_t;

  front_st_t         state_q;
  logic              valid_q;
  cfg_req_t          req_q;
  logic [NUM_CHAN:0] sel_q;
  logic [NUM_CHAN:0] sel_dec;

  // one-hot target from the raw address
  always_comb begin
    sel_dec = '0;
    for (int i = 0; i < NUM_CHAN; i++) begin
      if (int'(cfg_addr) == int'(ADDR_CHAN0) + i * CHAN_STRIDE) begin
        sel_dec[i] = 1'b1;  // channel hit
      end
    end
    if (sel_dec == '0) begin
      sel_dec[NUM_CHAN] = 1'b1;  // everything else goes to loop regs
    end
  end

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      state_q <= ST_IDLE;
      valid_q <= 1'b0;
      sel_q   <= '0;
    end else begin
      valid_q <= 1'b0;  // strobe lasts one cycle
      case (state_q)
        ST_IDLE: begin
          if (cfg_req) begin
            valid_q <= 1'b1;
            sel_q   <= sel_dec;
            state_q <= ST_WAIT_LOW;
          end
        end
        ST_WAIT_LOW: begin
          if (!cfg_req) state_q <= ST_IDLE;  // re-arm once host lets go
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request payload, held until the next accepted request
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && cfg_req) begin
      req_q.we    <= ~cfg_we_n;
      req_q.addr  <= cfg_addr;
      req_q.wdata <= cfg_wdata;
    end
  end

  assign acc.valid = valid_q;
  assign acc.req   = req_q;
  assign acc.sel   = sel_q;

endmodule

`default_nettype wire

// File: design/cfg_if.sv
// decoded register access, front end to register blocks
`timescale 1ns/1ps
`default_nettype none

interface cfg_if import clk_ctrl_pkg::*; #(
  parameter int NUM_CHAN = 2
) ();

  logic            valid;  // one-cycle access strobe
  cfg_req_t        req;    // write flag, address, write data
  logic [NUM_CHAN:0] sel;  // one-hot, top bit = loop registers

  modport src (
    output valid,
    output req,
    output sel
  );

  // keyword clash, so the register side is called regs
  modport regs (
    input valid,
    input req,
    input sel
  );

  modport mon (
    input valid,
    input req,
    input sel
  );

endinterface

`default_nettype wire

// File: design/clk_ctrl_pkg.sv
// register map of the pll config block
// addresses, field positions, reset words and the host request struct
`default_nettype none

package clk_ctrl_pkg;

  localparam int unsigned ADDR_W = 5;   // byte address
  localparam int unsigned DATA_W = 32;  // register width

  localparam logic [ADDR_W-1:0] ADDR_CHAN0 = 5'd0;   // post-scaler 0
  localparam logic [ADDR_W-1:0] ADDR_CHAN1 = 5'd4;   // post-scaler 1
  localparam logic [ADDR_W-1:0] ADDR_MUL   = 5'd8;   // prescale and multiplier
  localparam logic [ADDR_W-1:0] ADDR_SSC   = 5'd12;  // spread spectrum
  localparam logic [ADDR_W-1:0] ADDR_LDET  = 5'd16;  // lock detect, lock in bit 31
  localparam logic [ADDR_W-1:0] ADDR_LF    = 5'd20;  // loop filter word
  localparam logic [ADDR_W-1:0] ADDR_SCR0  = 5'd24;  // scratch
  localparam logic [ADDR_W-1:0] ADDR_SCR1  = 5'd28;  // scratch

  // channel register fields
  localparam int unsigned CH_L1_LSB   = 0;   // level-1 divider
  localparam int unsigned CH_L1_MSB   = 1;
  localparam int unsigned CH_RST_REL  = 2;   // pll reset release, chan 0 only
  localparam int unsigned CH_L2_LSB   = 4;   // level-2 divider
  localparam int unsigned CH_L2_MSB   = 11;
  localparam int unsigned CH_FRAC_LSB = 12;  // level-2 fraction
  localparam int unsigned CH_FRAC_MSB = 17;
  localparam int unsigned CH_EN       = 18;
  localparam int unsigned CH_BYP      = 19;

  // multiplier register fields
  localparam int unsigned MUL_INT_LSB  = 4;
  localparam int unsigned MUL_INT_MSB  = 14;
  localparam int unsigned MUL_FRAC_LSB = 15;
  localparam int unsigned MUL_FRAC_MSB = 26;
  localparam int unsigned MUL_IMODE    = 27;  // integer mode
  localparam int unsigned MUL_PRE_LSB  = 28;  // prescale
  localparam int unsigned MUL_PRE_MSB  = 31;

  // lock detect register fields
  localparam int unsigned LDET_CNT_MSB = 8;   // count in bits 8:0
  localparam int unsigned LDET_LF_LSB  = 9;   // loop filter upper bits
  localparam int unsigned LDET_LF_MSB  = 11;
  localparam int unsigned LDET_LOCK    = 31;  // lock on readback

  localparam logic [DATA_W-1:0] RST_CHAN = 32'd1 << CH_BYP;  // bypassed, disabled
  localparam logic [DATA_W-1:0] RST_MUL  = (32'd40 << MUL_INT_LSB) |
                                           (32'd1 << MUL_IMODE) |
                                           (32'd1 << MUL_PRE_LSB);
  localparam logic [DATA_W-1:0] RST_LDET = 32'h64;
  localparam logic [DATA_W-1:0] RST_LF   = 32'h269;

  typedef struct packed {
    logic              we;     // 1 = write
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } cfg_req_t;  // 38 bits

endpackage

`default_nettype wire
